//--- common/uart_cfg_pkg.sv
package uart_cfg_pkg;

	// default frame format, overridden through uart_top parameters
	localparam int DEF_DATA_WIDTH   = 8;    // data bits per frame
	localparam int DEF_CLKS_PER_BIT = 8;    // tx_clk cycles per bit, even and at least 4

	// depth of the i_serial synchronizer, a fixed property of the receiver
	localparam int SYNC_STAGES = 3;

	// parity setting derived at the top from PARITY_EN and PARITY_ODD
	typedef enum logic [1:0] {
		PARITY_NONE = 2'd0, // no parity bit in the frame
		PARITY_EVEN = 2'd1, // total count of ones incl. parity is even
		PARITY_ODD  = 2'd2  // total count of ones incl. parity is odd
	} parity_mode_t;

	// start + data + optional parity + stop
	function automatic int unsigned frame_bits(
		input int unsigned  width,
		input parity_mode_t mode
	);
		return width + ((mode == PARITY_NONE) ? 0 : 1) + 2;
	endfunction

	// counter width able to hold 0 .. n-1, never below one bit
	function automatic int unsigned count_width(
		input int unsigned n
	);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

//--- common/uart_state_pkg.sv
package uart_state_pkg;

	// transmit sequencer, idle line or frame on the wire
	typedef enum logic {
		TX_IDLE = 1'b0, // waiting for i_tx_valid
		TX_SEND = 1'b1  // shifting out start, data, parity, stop
	} tx_state_t;

	// receive sequencer, advanced only on mid-bit strobes
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0, // line idle, waiting for start pulse
		RX_START  = 3'd1, // checking the start bit at mid-bit
		RX_DATA   = 3'd2, // collecting DATA_WIDTH data bits
		RX_PARITY = 3'd3, // sampling the parity bit
		RX_STOP   = 3'd4  // sampling the stop bit, frame report
	} rx_state_t;

endpackage

//--- tx/tx_shift.sv
`timescale 1ns/10ps

module tx_shift import uart_cfg_pkg::*; #(
	parameter int           DATA_WIDTH  = DEF_DATA_WIDTH,
	parameter parity_mode_t PARITY_MODE = PARITY_EVEN
) (
	input  logic                  tx_clk,
	input  logic                  reset,
	input  logic                  i_load,     // word accepted, capture a new frame
	input  logic                  i_shift,    // bit boundary, move to the next bit
	input  logic [DATA_WIDTH-1:0] i_tx_data,
	output logic                  o_serial
);

	localparam int FRAME_BITS = frame_bits(DATA_WIDTH, PARITY_MODE);

	logic [FRAME_BITS-1:0] frame_q;    // bit 0 is the bit on the line
	logic [FRAME_BITS-1:0] frame_d;    // frame built from i_tx_data
	logic                  parity_bit;

	// even parity is the xor of the data, odd is its inverse
	assign parity_bit = (PARITY_MODE == PARITY_ODD) ? ~^i_tx_data : ^i_tx_data;

	always_comb begin
		frame_d                 = '1;         // stop bit and unused positions high
		frame_d[0]              = 1'b0;       // start bit
		frame_d[DATA_WIDTH:1]   = i_tx_data;  // data, lsb goes out first
		if (PARITY_MODE != PARITY_NONE) begin
			frame_d[DATA_WIDTH+1] = parity_bit; // parity just before stop
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			frame_q <= '1; // line idles high
		end else if (i_load) begin
			frame_q <= frame_d;
		end else if (i_shift) begin
			frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]}; // fill with ones behind the stop bit
		end
	end

	// registered drive, the line changes one cycle after load or shift
	assign o_serial = frame_q[0];

endmodule

//--- rx/rx_front.sv
`timescale 1ns/10ps

module rx_front import uart_cfg_pkg::*; #(
	parameter int DATA_WIDTH   = DEF_DATA_WIDTH,
	parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT
) (
	input  logic tx_clk,
	input  logic reset,
	input  logic i_serial,     // asynchronous line input
	input  logic i_rx_active,  // receive sequencer busy with a frame
	output logic o_start,      // one-cycle pulse on a falling edge while idle
	output logic o_strobe,     // mid-bit sample point
	output logic o_sample_bit  // synchronized line value
);

	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int CNT_W    = count_width(CLKS_PER_BIT);

	logic [SYNC_STAGES-1:0] sync_q;      // sync_q[0] is the metastable stage
	logic                   line_s;      // synchronized line
	logic                   line_prev_q; // line one cycle back, for edge detect
	logic                   line_fall;
	logic                   start_q;
	logic [CNT_W-1:0]       phase_cnt;   // cycles left to the next sample point
	logic                   strobe_due;

	assign line_s    = sync_q[SYNC_STAGES-1];
	assign line_fall = line_prev_q & ~line_s;

	// strobe at the end of each phase count while a frame is in progress
	assign strobe_due = i_rx_active && (phase_cnt == '0);

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			sync_q      <= '1; // idle line is high
			line_prev_q <= 1'b1;
			start_q     <= 1'b0;
			phase_cnt   <= '0;
		end else begin
			sync_q      <= {sync_q[SYNC_STAGES-2:0], i_serial};
			line_prev_q <= line_s;
			start_q     <= line_fall & ~i_rx_active; // edges inside a frame are data
			if (start_q) begin
				phase_cnt <= CNT_W'(HALF_BIT - 1); // first strobe half a bit in
			end else if (i_rx_active) begin
				if (phase_cnt == '0) begin
					phase_cnt <= CNT_W'(CLKS_PER_BIT - 1); // then once per bit
				end else begin
					phase_cnt <= phase_cnt - 1'b1;
				end
			end
		end
	end

	assign o_start      = start_q;
	assign o_strobe     = strobe_due;
	assign o_sample_bit = line_s; // read by consumers only with o_strobe

endmodule

//--- rx/rx_shift.sv
`timescale 1ns/10ps

module rx_shift import uart_cfg_pkg::*; #(
	parameter int           DATA_WIDTH  = DEF_DATA_WIDTH,
	parameter parity_mode_t PARITY_MODE = PARITY_EVEN
) (
	input  logic                  tx_clk,
	input  logic                  reset,
	input  logic                  i_sample_bit,     // line value at mid-bit
	input  logic                  i_capture_data,   // sample is a data bit
	input  logic                  i_capture_parity, // sample is the parity bit
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_parity_bad
);

	logic [DATA_WIDTH-1:0] data_q;        // deserializer, msb side filled first
	logic                  parity_bad_q;
	logic                  expected_parity;

	// parity the transmitter would have sent for the collected data
	assign expected_parity = (PARITY_MODE == PARITY_ODD) ? ~^data_q : ^data_q;

	// lsb arrives first, so shift right and enter at the top
	always_ff @(posedge tx_clk) begin
		if (i_capture_data) begin
			data_q <= {i_sample_bit, data_q[DATA_WIDTH-1:1]};
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			parity_bad_q <= 1'b0;
		end else if (i_capture_data) begin
			parity_bad_q <= 1'b0; // new frame, drop the old verdict
		end else if (i_capture_parity && (PARITY_MODE != PARITY_NONE)) begin
			parity_bad_q <= i_sample_bit ^ expected_parity; // valid the next cycle
		end
	end

	// data stays put between frames, changes with the first data capture
	assign o_rx_data    = data_q;
	assign o_parity_bad = parity_bad_q;

endmodule

//--- rtl/uart_ctrl.sv
`timescale 1ns/10ps

module uart_ctrl
	import uart_cfg_pkg::*;
	import uart_state_pkg::*;
#(
	parameter int           DATA_WIDTH   = DEF_DATA_WIDTH,
	parameter int           CLKS_PER_BIT = DEF_CLKS_PER_BIT,
	parameter parity_mode_t PARITY_MODE  = PARITY_EVEN
) (
	input  logic tx_clk,
	input  logic reset,
	// transmit handshake
	input  logic i_tx_valid,
	output logic o_tx_ready,
	output logic o_tx_load,        // to tx_shift, capture the frame
	output logic o_tx_shift,       // to tx_shift, next bit
	// receive front end
	input  logic i_start,
	input  logic i_strobe,
	input  logic i_sample_bit,
	output logic o_rx_active,
	// receive datapath
	output logic o_capture_data,
	output logic o_capture_parity,
	input  logic i_parity_bad,
	// frame report
	output logic o_rx_valid,
	output logic o_rx_error
);

	localparam int FRAME_BITS = frame_bits(DATA_WIDTH, PARITY_MODE);
	localparam int BAUD_W     = count_width(CLKS_PER_BIT);
	localparam int FBIT_W     = count_width(FRAME_BITS);
	localparam int DBIT_W     = count_width(DATA_WIDTH);

	tx_state_t         tx_state;
	logic [BAUD_W-1:0] baud_cnt;    // cycle within the current tx bit
	logic [FBIT_W-1:0] tx_bit_cnt;  // bit of the frame on the line
	logic              baud_end;
	logic              tx_accept;

	rx_state_t         rx_state;
	logic [DBIT_W-1:0] rx_bit_cnt;  // data bits collected
	logic              rx_valid_q;
	logic              rx_error_q;

	// transmit side

	assign o_tx_ready = (tx_state == TX_IDLE); // low for the whole frame
	assign tx_accept  = i_tx_valid & o_tx_ready;
	assign baud_end   = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

	assign o_tx_load  = tx_accept;
	assign o_tx_shift = (tx_state == TX_SEND) && baud_end;

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			tx_state   <= TX_IDLE;
			baud_cnt   <= '0;
			tx_bit_cnt <= '0;
		end else begin
			case (tx_state)
				TX_IDLE: begin
					if (tx_accept) begin
						tx_state   <= TX_SEND; // start bit shows next cycle
						baud_cnt   <= '0;
						tx_bit_cnt <= '0;
					end
				end
				TX_SEND: begin
					if (baud_end) begin
						baud_cnt <= '0;
						if (tx_bit_cnt == FBIT_W'(FRAME_BITS - 1)) begin
							tx_state <= TX_IDLE; // stop bit done, ready rises
						end else begin
							tx_bit_cnt <= tx_bit_cnt + 1'b1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	// receive side

	assign o_rx_active      = (rx_state != RX_IDLE);
	assign o_capture_data   = (rx_state == RX_DATA) && i_strobe;
	assign o_capture_parity = (rx_state == RX_PARITY) && i_strobe;

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			rx_state   <= RX_IDLE;
			rx_bit_cnt <= '0;
			rx_valid_q <= 1'b0;
			rx_error_q <= 1'b0;
		end else begin
			rx_valid_q <= 1'b0; // single-cycle report
			case (rx_state)
				RX_IDLE: begin
					if (i_start) begin
						rx_state <= RX_START;
					end
				end
				RX_START: begin
					if (i_strobe) begin
						if (i_sample_bit) begin
							rx_state <= RX_IDLE; // short low pulse, not a start bit
						end else begin
							rx_state   <= RX_DATA;
							rx_bit_cnt <= '0;
						end
					end
				end
				RX_DATA: begin
					if (i_strobe) begin
						if (rx_bit_cnt == DBIT_W'(DATA_WIDTH - 1)) begin
							rx_state <= (PARITY_MODE == PARITY_NONE) ? RX_STOP : RX_PARITY;
						end else begin
							rx_bit_cnt <= rx_bit_cnt + 1'b1;
						end
					end
				end
				RX_PARITY: begin
					if (i_strobe) begin
						rx_state <= RX_STOP; // parity verdict settles meanwhile
					end
				end
				RX_STOP: begin
					if (i_strobe) begin
						rx_state   <= RX_IDLE;
						rx_valid_q <= 1'b1;
						rx_error_q <= i_parity_bad | ~i_sample_bit; // framing or parity
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	assign o_rx_valid = rx_valid_q;
	assign o_rx_error = rx_error_q; // held until the next frame report

endmodule

//--- rtl/uart_top.sv
`timescale 1ns/10ps

module uart_top import uart_cfg_pkg::*; #(
	parameter int DATA_WIDTH   = DEF_DATA_WIDTH,
	parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT,
	parameter bit PARITY_EN    = 1'b1,
	parameter bit PARITY_ODD   = 1'b0  // even parity unless set
) (
	input  logic                  tx_clk,
	input  logic                  reset,
	input  logic                  i_tx_valid,
	input  logic [DATA_WIDTH-1:0] i_tx_data,
	output logic                  o_tx_ready,
	output logic                  o_serial,
	input  logic                  i_serial,
	output logic                  o_rx_valid,
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_rx_error
);

	// the parameter PARITY_ODD hides the enum literal, hence the package scope
	localparam parity_mode_t PARITY_MODE = !PARITY_EN ? PARITY_NONE :
		(PARITY_ODD ? uart_cfg_pkg::PARITY_ODD : PARITY_EVEN);

	logic tx_load;
	logic tx_shift_pulse;
	logic rx_active;
	logic rx_start;
	logic rx_strobe;
	logic rx_sample_bit;
	logic capture_data;
	logic capture_parity;
	logic parity_bad;

	uart_ctrl #(
		.DATA_WIDTH(DATA_WIDTH), .CLKS_PER_BIT(CLKS_PER_BIT), .PARITY_MODE(PARITY_MODE)
	) ctrl_i (
		.tx_clk(tx_clk), .reset(reset),
		.i_tx_valid(i_tx_valid), .o_tx_ready(o_tx_ready),
		.o_tx_load(tx_load), .o_tx_shift(tx_shift_pulse),
		.i_start(rx_start), .i_strobe(rx_strobe), .i_sample_bit(rx_sample_bit),
		.o_rx_active(rx_active),
		.o_capture_data(capture_data), .o_capture_parity(capture_parity),
		.i_parity_bad(parity_bad),
		.o_rx_valid(o_rx_valid), .o_rx_error(o_rx_error)
	);

	tx_shift #(.DATA_WIDTH(DATA_WIDTH), .PARITY_MODE(PARITY_MODE)) tx_shift_i (
		.tx_clk(tx_clk), .reset(reset),
		.i_load(tx_load), .i_shift(tx_shift_pulse), .i_tx_data(i_tx_data),
		.o_serial(o_serial)
	);

	rx_front #(.DATA_WIDTH(DATA_WIDTH), .CLKS_PER_BIT(CLKS_PER_BIT)) rx_front_i (
		.tx_clk(tx_clk), .reset(reset),
		.i_serial(i_serial), .i_rx_active(rx_active),
		.o_start(rx_start), .o_strobe(rx_strobe), .o_sample_bit(rx_sample_bit)
	);

	rx_shift #(.DATA_WIDTH(DATA_WIDTH), .PARITY_MODE(PARITY_MODE)) rx_shift_i (
		.tx_clk(tx_clk), .reset(reset),
		.i_sample_bit(rx_sample_bit),
		.i_capture_data(capture_data), .i_capture_parity(capture_parity),
		.o_rx_data(o_rx_data), .o_parity_bad(parity_bad)
	);

endmodule

//--- bench/uart_props.sv
`timescale 1ns/10ps

module uart_props import uart_cfg_pkg::*; #(
	parameter int DATA_WIDTH   = DEF_DATA_WIDTH,
	parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT,
	parameter bit PARITY_EN    = 1'b1
) (
	input logic tx_clk,
	input logic reset,
	input logic i_tx_ready,
	input logic i_line,     // transmit line
	input logic i_rx_valid
);

	localparam int FRAME_CYC =
		frame_bits(DATA_WIDTH, PARITY_EN ? PARITY_EVEN : PARITY_NONE) * CLKS_PER_BIT;

	int busy_cycles;    // cycles since ready fell
	int fail_count = 0; // failed assertions so far

	always_ff @(posedge tx_clk) begin
		if (reset || i_tx_ready) begin
			busy_cycles <= 0;
		end else begin
			busy_cycles <= busy_cycles + 1;
		end
	end

	idle_line_high: assert property (@(posedge tx_clk) disable iff (reset)
		i_tx_ready |-> i_line)
		else begin
			$error("transmit line low while the transmitter is idle");
			fail_count++;
		end

	rx_valid_pulse: assert property (@(posedge tx_clk) disable iff (reset)
		i_rx_valid |=> !i_rx_valid)
		else begin
			$error("receive valid held for two cycles");
			fail_count++;
		end

	// one frame on the wire, then ready is back
	tx_frame_bounded: assert property (@(posedge tx_clk) disable iff (reset)
		!i_tx_ready |-> (busy_cycles < FRAME_CYC))
		else begin
			$error("transmitter busy longer than one frame");
			fail_count++;
		end

endmodule

bind uart_top uart_props #(
	.DATA_WIDTH(DATA_WIDTH), .CLKS_PER_BIT(CLKS_PER_BIT), .PARITY_EN(PARITY_EN)
) props_i (
	.tx_clk(tx_clk), .reset(reset),
	.i_tx_ready(o_tx_ready), .i_line(o_serial), .i_rx_valid(o_rx_valid)
);

//--- bench/uart_tb.sv
`timescale 1ns/10ps

module uart_tb import uart_cfg_pkg::*; ();

	localparam int DATA_WIDTH   = DEF_DATA_WIDTH;
	localparam int CLKS_PER_BIT = DEF_CLKS_PER_BIT;
	localparam int FRAME_BITS   = frame_bits(DATA_WIDTH, PARITY_EVEN);
	localparam int FRAME_CYC    = FRAME_BITS * CLKS_PER_BIT;
	localparam int NUM_RANDOM   = 40;
	localparam int NUM_FRAMES   = NUM_RANDOM + 6;             // shape, random, 2 parity, 2 stop, glitch
	localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYC * 2; // twice the bare line time

	localparam logic [1:0] FAULT_NONE   = 2'd0;
	localparam logic [1:0] FAULT_PARITY = 2'd1; // parity bit inverted on the line
	localparam logic [1:0] FAULT_STOP   = 2'd2; // stop bit pulled low

	logic                  tx_clk     = 1'b0;
	logic                  reset      = 1'b1;
	logic                  tx_valid   = 1'b0;
	logic [DATA_WIDTH-1:0] tx_data    = '0;
	logic                  tx_ready;
	logic                  serial_out;
	logic                  serial_in;  // loopback with fault injection
	logic                  rx_valid;
	logic [DATA_WIDTH-1:0] rx_data;
	logic                  rx_error;

	logic [1:0]            next_fault = FAULT_NONE; // applied to the next accepted frame
	logic [1:0]            cur_fault  = FAULT_NONE; // fault of the frame on the line
	logic                  in_frame   = 1'b0;
	int                    frame_cyc  = 0;          // cycles since acceptance
	logic                  glitch_low = 1'b0;
	logic                  fault_on;

	logic [DATA_WIDTH:0]   exp_q[$];                // {error, data} per accepted word
	int                    sent_count  = 0;
	int                    rx_count    = 0;
	int                    check_count = 0;
	int                    error_count = 0;
	int                    cycle_count = 0;
	logic [31:0]           lcg_state   = 32'd5;
	string                 test_name   = "reset_state";

	uart_top #(
		.DATA_WIDTH(DATA_WIDTH), .CLKS_PER_BIT(CLKS_PER_BIT), .PARITY_EN(1'b1), .PARITY_ODD(1'b0)
	) dut_i (
		.tx_clk(tx_clk), .reset(reset),
		.i_tx_valid(tx_valid), .i_tx_data(tx_data), .o_tx_ready(tx_ready),
		.o_serial(serial_out), .i_serial(serial_in),
		.o_rx_valid(rx_valid), .o_rx_data(rx_data), .o_rx_error(rx_error)
	);

	always #20 tx_clk = ~tx_clk; // 40 ns period

	// fault window is one whole bit of the tracked frame
	assign fault_on = in_frame && (
		((cur_fault == FAULT_PARITY) && (frame_cyc / CLKS_PER_BIT == DATA_WIDTH + 1)) ||
		((cur_fault == FAULT_STOP) && (frame_cyc / CLKS_PER_BIT == FRAME_BITS - 1)));
	assign serial_in = glitch_low ? 1'b0 :
		(fault_on ? ((cur_fault == FAULT_PARITY) ? ~serial_out : 1'b0) : serial_out);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// line level of frame bit k: start, data lsb first, even parity, stop
	function automatic logic frame_bit(input logic [DATA_WIDTH-1:0] data, input int k);
		int ones;
		ones = 0;
		for (int i = 0; i < DATA_WIDTH; i++) begin
			ones += int'(data[i]);
		end
		if (k == 0) begin
			return 1'b0;
		end else if (k <= DATA_WIDTH) begin
			return data[k-1];
		end else if (k == DATA_WIDTH + 1) begin
			return ones % 2 == 1; // makes the total count of ones even
		end
		return 1'b1;
	endfunction

	// expected receive report, any line fault marks the frame bad but keeps its data
	function automatic logic [DATA_WIDTH:0] expect_rx(
		input logic [DATA_WIDTH-1:0] data,
		input logic [1:0]            fault
	);
		return {fault != FAULT_NONE, data};
	endfunction

	task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic next_word(output logic [DATA_WIDTH-1:0] word);
		lcg_state = lcg_next(lcg_state);
		word      = lcg_state[DATA_WIDTH+15:16]; // upper bits, low lcg bits are weak
	endtask

	// returns on the edge that accepts the word, valid stays high
	task automatic send_word(input logic [DATA_WIDTH-1:0] data);
		tx_data  <= data;
		tx_valid <= 1'b1;
		do begin
			@(posedge tx_clk);
		end while (!tx_ready);
	endtask

	task automatic wait_idle();
		@(posedge tx_clk);
		while (rx_count < sent_count) begin
			@(posedge tx_clk);
		end
		repeat (4) @(posedge tx_clk);
	endtask

	task automatic send_frame(input logic [DATA_WIDTH-1:0] data, input logic [1:0] fault);
		next_fault <= fault;
		send_word(data);
		tx_valid   <= 1'b0;
		next_fault <= FAULT_NONE;
		wait_idle();
	endtask

	// tracks each accepted frame and queues its expected report
	always @(posedge tx_clk) begin
		if (reset) begin
			in_frame <= 1'b0;
		end else if (tx_valid && tx_ready) begin
			exp_q.push_back(expect_rx(tx_data, next_fault));
			sent_count <= sent_count + 1;
			cur_fault  <= next_fault;
			in_frame   <= 1'b1;
			frame_cyc  <= 0;
		end else if (in_frame) begin
			if (frame_cyc == FRAME_CYC - 1) begin
				in_frame <= 1'b0; // stop bit over
			end else begin
				frame_cyc <= frame_cyc + 1;
			end
		end
	end

	always @(posedge tx_clk) begin
		logic [DATA_WIDTH:0] expected;
		if (!reset && rx_valid) begin
			rx_count <= rx_count + 1;
			if (exp_q.size() == 0) begin
				error_count++;
				$display("ERROR %s: receiver reported a frame that was never sent", test_name);
			end else begin
				expected = exp_q.pop_front();
				check("rx_data", 32'(expected[DATA_WIDTH-1:0]), 32'(rx_data));
				check("rx_error", 32'(expected[DATA_WIDTH]), 32'(rx_error));
			end
		end
	end

	always @(posedge tx_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("ERROR: timeout after %0d cycles, a frame never completed", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		logic [DATA_WIDTH-1:0] word;
		int                    low_cycles;
		int                    rx_before;
		repeat (16) @(posedge tx_clk);
		reset <= 1'b0;

		repeat (4) begin // idle outputs until the first word
			@(posedge tx_clk);
			check("serial", 32'd1, 32'(serial_out));
			check("tx_ready", 32'd1, 32'(tx_ready));
			check("rx_valid", 32'd0, 32'(rx_valid));
		end

		test_name = "frame_shape";
		next_word(word);
		send_word(word);
		tx_valid <= 1'b0;
		low_cycles = 0;
		for (int c = 0; c < FRAME_CYC; c++) begin
			@(posedge tx_clk); // sees the level of cycle c after acceptance
			if (!tx_ready) begin
				low_cycles++;
			end
			if (c % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
				check($sformatf("bit_%0d", c / CLKS_PER_BIT),
					32'(frame_bit(word, c / CLKS_PER_BIT)), 32'(serial_out));
			end
		end
		@(posedge tx_clk);
		check("ready_low_cycles", 32'(FRAME_CYC), 32'(low_cycles));
		check("ready_after_frame", 32'd1, 32'(tx_ready));
		wait_idle();

		test_name = "random_loopback";
		for (int n = 0; n < NUM_RANDOM; n++) begin
			next_word(word);
			send_word(word); // next word waits with valid high
		end
		tx_valid <= 1'b0;
		wait_idle();
		check("received_count", 32'(sent_count), 32'(rx_count));

		test_name = "parity_fault";
		next_word(word);
		send_frame(word, FAULT_PARITY);
		next_word(word);
		send_frame(word, FAULT_NONE);

		test_name = "stop_fault";
		next_word(word);
		send_frame(word, FAULT_STOP);
		next_word(word);
		send_frame(word, FAULT_NONE);

		test_name = "glitch";
		rx_before = rx_count;
		glitch_low <= 1'b1; // one cycle, below a quarter bit
		@(posedge tx_clk);
		glitch_low <= 1'b0;
		repeat (2 * FRAME_CYC) @(posedge tx_clk);
		check("frames_after_glitch", 32'(rx_before), 32'(rx_count));
		next_word(word);
		send_frame(word, FAULT_NONE);

		test_name = "summary";
		check("frames_outstanding", 32'd0, 32'(exp_q.size()));
		check("received_total", 32'(sent_count), 32'(rx_count));
		error_count += dut_i.props_i.fail_count;
		$display("checks: %0d, errors: %0d, assertion failures: %0d, frames: %0d",
			check_count, error_count, dut_i.props_i.fail_count, rx_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
common/uart_cfg_pkg.sv
common/uart_state_pkg.sv
tx/tx_shift.sv
rx/rx_front.sv
rx/rx_shift.sv
rtl/uart_ctrl.sv
rtl/uart_top.sv
bench/uart_props.sv
bench/uart_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= uart_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Simulation FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test: failing run, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
